// ==== design/colmix_video_pkg.sv ====
// shared pixel, layer and colour definitions for the colour mixer video path
package colmix_video_pkg;

    // layer colour index is a 5-bit palette line on top of a 4-bit pen
    localparam int LYR_W = 9;
    localparam int FIX_W = 8;
    localparam int PEN_W = 4;
    localparam int PRI_W = 2;

    // object pen reserved for shadow, never drawn when shadow is set
    localparam int SHADOW_PEN = 15;

    // BGR555 palette word and 8-bit output channels
    localparam int CH_W  = 5;
    localparam int COL_W = 3 * CH_W;
    localparam int OUT_W = 8;

    // one 512-entry palette bank per layer
    localparam int BANK_W = 2;

    // winning layer, encoding also decoded by the testbench
    typedef enum logic [2:0] {
        LAYER_BACK = 3'd0,
        LAYER_FIX  = 3'd1,
        LAYER_A    = 3'd2,
        LAYER_B    = 3'd3,
        LAYER_OBJ  = 3'd4
    } layer_sel_e;

endpackage

// ==== design/colmix_regs_pkg.sv ====
// APB register map and control field widths for the colour mixer CPU port
package colmix_regs_pkg;

    localparam int ADDR_W = 13;
    localparam int DATA_W = 16;

    // byte addresses, all accesses are 16-bit words
    localparam logic [ADDR_W-1:0] PAL_BASE = 13'h0000;
    localparam logic [ADDR_W-1:0] REG_PRIO = 13'h1000;
    localparam logic [ADDR_W-1:0] REG_DIM  = 13'h1002;

    // one over/under bit per object priority tag
    localparam int OVR_W = 4;
    // dim level, dim_pol and dim_all sit just above it
    localparam int DIM_W = 3;

    typedef enum logic [2:0] {
        ACC_NONE = 3'd0,
        ACC_PAL  = 3'd1,
        ACC_PRIO = 3'd2,
        ACC_DIM  = 3'd3,
        ACC_BAD  = 3'd4
    } apb_access_e;

endpackage

// ==== design/colmix_apb.sv ====
// APB slave that owns the mixer control registers and the CPU side of the palette
`timescale 1ns/10ps

module colmix_apb #(
    parameter int PAL_AW = 11
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [colmix_regs_pkg::ADDR_W-1:0] paddr,
    input  logic [colmix_regs_pkg::DATA_W-1:0] pwdata,
    output logic [colmix_regs_pkg::DATA_W-1:0] prdata,
    output logic                               pready,
    output logic                               pslverr,
    output logic [PAL_AW-1:0]                  pal_cpu_addr,
    output logic                               pal_cpu_we,
    output logic [colmix_video_pkg::COL_W-1:0] pal_cpu_wdata,
    input  logic [colmix_video_pkg::COL_W-1:0] pal_cpu_rdata,
    output logic [colmix_regs_pkg::OVR_W-1:0]  obj_over_a,
    output logic [colmix_regs_pkg::DIM_W-1:0]  dim,
    output logic                               dim_pol,
    output logic                               dim_all
);

    localparam int ADDR_W   = colmix_regs_pkg::ADDR_W;
    localparam int DATA_W   = colmix_regs_pkg::DATA_W;
    localparam int COL_W    = colmix_video_pkg::COL_W;
    localparam int OVR_W    = colmix_regs_pkg::OVR_W;
    localparam int DIM_W    = colmix_regs_pkg::DIM_W;
    // two bytes per palette word
    localparam int PAL_SPAN = 2 * (2 ** PAL_AW);

    typedef enum logic {
        IDLE,
        PAL_WAIT
    } state_e;

    state_e                        state;
    colmix_regs_pkg::apb_access_e  acc_dec;
    colmix_regs_pkg::apb_access_e  acc_q;
    logic [ADDR_W-1:0]             pal_off;
    logic                          access;
    logic                          pal_rd;
    logic                          wr_en;

    // offset wraps below the base, so one compare covers both ends
    assign pal_off = paddr - colmix_regs_pkg::PAL_BASE;

    always_comb begin
        if (!psel) begin
            acc_dec = colmix_regs_pkg::ACC_NONE;
        end else if (paddr[0]) begin
            acc_dec = colmix_regs_pkg::ACC_BAD;
        end else if (paddr == colmix_regs_pkg::REG_PRIO) begin
            acc_dec = colmix_regs_pkg::ACC_PRIO;
        end else if (paddr == colmix_regs_pkg::REG_DIM) begin
            acc_dec = colmix_regs_pkg::ACC_DIM;
        end else if (int'(pal_off) < PAL_SPAN) begin
            acc_dec = colmix_regs_pkg::ACC_PAL;
        end else begin
            acc_dec = colmix_regs_pkg::ACC_BAD;
        end
    end

    assign access  = psel & penable;
    assign pal_rd  = (acc_q == colmix_regs_pkg::ACC_PAL) & ~pwrite;
    assign wr_en   = access & pwrite & (state == IDLE);
    // palette reads hold off one cycle for the registered RAM output
    assign pready  = access & ~(pal_rd & (state == IDLE));
    assign pslverr = access & (acc_q == colmix_regs_pkg::ACC_BAD);

    assign pal_cpu_addr  = pal_off[PAL_AW:1];
    assign pal_cpu_we    = wr_en & (acc_q == colmix_regs_pkg::ACC_PAL);
    assign pal_cpu_wdata = pwdata[COL_W-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            acc_q <= colmix_regs_pkg::ACC_NONE;
        end else begin
            // kind latched in setup, held through the access phase
            if (!access) begin
                acc_q <= acc_dec;
            end
            case (state)
                IDLE:     if (access && pal_rd) state <= PAL_WAIT;
                PAL_WAIT: state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            obj_over_a <= '0;
            dim        <= '0;
            dim_pol    <= 1'b0;
            dim_all    <= 1'b0;
        end else if (wr_en) begin
            if (acc_q == colmix_regs_pkg::ACC_PRIO) begin
                obj_over_a <= pwdata[OVR_W-1:0];
            end
            if (acc_q == colmix_regs_pkg::ACC_DIM) begin
                dim     <= pwdata[DIM_W-1:0];
                dim_pol <= pwdata[DIM_W];
                dim_all <= pwdata[DIM_W+1];
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (acc_q)
                colmix_regs_pkg::ACC_PAL:  prdata = {{(DATA_W-COL_W){1'b0}}, pal_cpu_rdata};
                colmix_regs_pkg::ACC_PRIO: prdata = {{(DATA_W-OVR_W){1'b0}}, obj_over_a};
                colmix_regs_pkg::ACC_DIM:
                    prdata = {{(DATA_W-DIM_W-2){1'b0}}, dim_all, dim_pol, dim};
                default:                   prdata = '0;
            endcase
        end
    end

endmodule

// ==== design/colmix_prio.sv ====
// layer priority resolver, picks the visible layer and registers its palette address
`timescale 1ns/10ps

module colmix_prio #(
    parameter int PAL_AW = 11
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               pxl_cen,
    input  logic                               lhbl,
    input  logic                               lvbl,
    input  logic [colmix_video_pkg::FIX_W-1:0] fix_pxl,
    input  logic [colmix_video_pkg::LYR_W-1:0] lyra_pxl,
    input  logic [colmix_video_pkg::LYR_W-1:0] lyrb_pxl,
    input  logic [colmix_video_pkg::LYR_W-1:0] obj_pxl,
    input  logic [colmix_video_pkg::PRI_W-1:0] obj_pri,
    input  logic                               shadow,
    input  logic [colmix_regs_pkg::OVR_W-1:0]  obj_over_a,
    output logic [PAL_AW-1:0]                  pal_addr,
    output logic                               shade,
    output logic                               blank_n
);

    localparam int LYR_W  = colmix_video_pkg::LYR_W;
    localparam int FIX_W  = colmix_video_pkg::FIX_W;
    localparam int PEN_W  = colmix_video_pkg::PEN_W;
    localparam int BANK_W = colmix_video_pkg::BANK_W;
    localparam int FULL_W = BANK_W + LYR_W;
    localparam logic [PEN_W-1:0] SHD_PEN = PEN_W'(colmix_video_pkg::SHADOW_PEN);

    colmix_video_pkg::layer_sel_e win;
    logic [FULL_W-1:0]            addr_nx;
    logic                         fix_op;
    logic                         obj_shd;
    logic                         obj_op;
    logic                         a_op;
    logic                         b_op;
    logic                         obj_over;

    // pen zero is transparent on every layer
    assign fix_op   = |fix_pxl[PEN_W-1:0];
    assign a_op     = |lyra_pxl[PEN_W-1:0];
    assign b_op     = |lyrb_pxl[PEN_W-1:0];
    assign obj_shd  = shadow & (obj_pxl[PEN_W-1:0] == SHD_PEN);
    assign obj_op   = |obj_pxl[PEN_W-1:0] & ~obj_shd;
    assign obj_over = obj_over_a[obj_pri];

    always_comb begin
        if (fix_op) begin
            win = colmix_video_pkg::LAYER_FIX;
        end else if (obj_op && obj_over) begin
            win = colmix_video_pkg::LAYER_OBJ;
        end else if (a_op) begin
            win = colmix_video_pkg::LAYER_A;
        end else if (obj_op) begin
            // object tucked under A but still above B
            win = colmix_video_pkg::LAYER_OBJ;
        end else if (b_op) begin
            win = colmix_video_pkg::LAYER_B;
        end else begin
            win = colmix_video_pkg::LAYER_BACK;
        end
    end

    // bank number sits above the 9-bit index
    always_comb begin
        case (win)
            colmix_video_pkg::LAYER_FIX:
                addr_nx = {BANK_W'(0), {(LYR_W-FIX_W){1'b0}}, fix_pxl};
            colmix_video_pkg::LAYER_OBJ: addr_nx = {BANK_W'(1), obj_pxl};
            colmix_video_pkg::LAYER_A:   addr_nx = {BANK_W'(2), lyra_pxl};
            colmix_video_pkg::LAYER_B:   addr_nx = {BANK_W'(3), lyrb_pxl};
            default:                     addr_nx = '0;
        endcase
    end

    // stage 1
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pal_addr <= '0;
            shade    <= 1'b0;
            blank_n  <= 1'b0;
        end else if (pxl_cen) begin
            pal_addr <= PAL_AW'(addr_nx);
            shade    <= obj_shd;
            blank_n  <= lhbl & lvbl;
        end
    end

endmodule

// ==== design/colmix_pal_ram.sv ====
// dual-port palette RAM, CPU port every clock and video port on the pixel enable
`timescale 1ns/10ps

module colmix_pal_ram #(
    parameter int PAL_AW = 11
) (
    input  logic                               clk,
    input  logic                               pxl_cen,
    input  logic [PAL_AW-1:0]                  pal_cpu_addr,
    input  logic                               pal_cpu_we,
    input  logic [colmix_video_pkg::COL_W-1:0] pal_cpu_wdata,
    output logic [colmix_video_pkg::COL_W-1:0] pal_cpu_rdata,
    input  logic [PAL_AW-1:0]                  pal_addr,
    input  logic                               shade_in,
    input  logic                               blank_n_in,
    output logic [colmix_video_pkg::COL_W-1:0] pal_color,
    output logic                               shade_out,
    output logic                               blank_n_out
);

    localparam int COL_W = colmix_video_pkg::COL_W;
    localparam int DEPTH = 2 ** PAL_AW;

    logic [COL_W-1:0] mem [DEPTH];

    // palette powers up black
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // cpu port, read returns the old word on a write cycle
    always @(posedge clk) begin
        if (pal_cpu_we) begin
            mem[pal_cpu_addr] <= pal_cpu_wdata;
        end
        pal_cpu_rdata <= mem[pal_cpu_addr];
    end

    // stage 2, flags follow the colour
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pal_color   <= mem[pal_addr];
            shade_out   <= shade_in;
            blank_n_out <= blank_n_in;
        end
    end

endmodule

// ==== design/colmix_bright.sv ====
// brightness stage, applies shadow and dim, expands BGR555 to 8-bit RGB and blanks
`timescale 1ns/10ps

module colmix_bright (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               pxl_cen,
    input  logic [colmix_video_pkg::COL_W-1:0] pal_color,
    input  logic                               shade,
    input  logic                               blank_n,
    input  logic [colmix_regs_pkg::DIM_W-1:0]  dim,
    input  logic                               dim_pol,
    input  logic                               dim_all,
    output logic [colmix_video_pkg::OUT_W-1:0] red,
    output logic [colmix_video_pkg::OUT_W-1:0] green,
    output logic [colmix_video_pkg::OUT_W-1:0] blue
);

    localparam int CH_W  = colmix_video_pkg::CH_W;
    localparam int COL_W = colmix_video_pkg::COL_W;
    localparam int OUT_W = colmix_video_pkg::OUT_W;
    localparam int DIM_W = colmix_regs_pkg::DIM_W;
    localparam int XW    = OUT_W - CH_W;
    // unity gain, the scale is gain/8
    localparam logic [DIM_W:0] FULL_GAIN = 1 << DIM_W;

    logic             do_dim;
    logic [DIM_W:0]   gain;
    logic [COL_W-1:0] col;

    // expand by repeating the top bits, then scale and truncate
    function automatic logic [OUT_W-1:0] scale_ch(
        input logic [CH_W-1:0] c,
        input logic [DIM_W:0]  k
    );
        logic [OUT_W-1:0]       full;
        logic [OUT_W+DIM_W-1:0] prod;
        full = {c, c[CH_W-1 -: XW]};
        prod = full * k;
        return prod[OUT_W+DIM_W-1 -: OUT_W];
    endfunction

    assign col    = pal_color;
    assign do_dim = (shade ^ dim_pol) | dim_all;
    assign gain   = do_dim ? FULL_GAIN - {1'b0, dim} : FULL_GAIN;

    // stage 3
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (pxl_cen) begin
            if (blank_n) begin
                red   <= scale_ch(col[CH_W-1:0], gain);
                green <= scale_ch(col[2*CH_W-1 -: CH_W], gain);
                blue  <= scale_ch(col[3*CH_W-1 -: CH_W], gain);
            end else begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end
        end
    end

endmodule

// ==== design/colmix_top.sv ====
// colour mixer top level, wires the APB block to the three-stage video pipeline
`timescale 1ns/10ps

module colmix_top #(
    parameter int PAL_AW = 11
) (
    input  logic                               clk,
    input  logic                               rst,
    // cpu bus
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [colmix_regs_pkg::ADDR_W-1:0] paddr,
    input  logic [colmix_regs_pkg::DATA_W-1:0] pwdata,
    output logic [colmix_regs_pkg::DATA_W-1:0] prdata,
    output logic                               pready,
    output logic                               pslverr,
    // layer pixels
    input  logic                               pxl_cen,
    input  logic                               lhbl,
    input  logic                               lvbl,
    input  logic [colmix_video_pkg::FIX_W-1:0] fix_pxl,
    input  logic [colmix_video_pkg::LYR_W-1:0] lyra_pxl,
    input  logic [colmix_video_pkg::LYR_W-1:0] lyrb_pxl,
    input  logic [colmix_video_pkg::LYR_W-1:0] obj_pxl,
    input  logic [colmix_video_pkg::PRI_W-1:0] obj_pri,
    input  logic                               shadow,
    // final colour
    output logic [colmix_video_pkg::OUT_W-1:0] red,
    output logic [colmix_video_pkg::OUT_W-1:0] green,
    output logic [colmix_video_pkg::OUT_W-1:0] blue
);

    logic [PAL_AW-1:0]                  pal_cpu_addr;
    logic                               pal_cpu_we;
    logic [colmix_video_pkg::COL_W-1:0] pal_cpu_wdata;
    logic [colmix_video_pkg::COL_W-1:0] pal_cpu_rdata;
    logic [colmix_regs_pkg::OVR_W-1:0]  obj_over_a;
    logic [colmix_regs_pkg::DIM_W-1:0]  dim;
    logic                               dim_pol;
    logic                               dim_all;
    logic [PAL_AW-1:0]                  pal_addr;
    logic                               shade;
    logic                               blank_n;
    logic [colmix_video_pkg::COL_W-1:0] pal_color;
    logic                               shade_d;
    logic                               blank_n_d;

    colmix_apb #(.PAL_AW(PAL_AW)) u_apb (
        .clk           (clk),
        .rst           (rst),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .pal_cpu_addr  (pal_cpu_addr),
        .pal_cpu_we    (pal_cpu_we),
        .pal_cpu_wdata (pal_cpu_wdata),
        .pal_cpu_rdata (pal_cpu_rdata),
        .obj_over_a    (obj_over_a),
        .dim           (dim),
        .dim_pol       (dim_pol),
        .dim_all       (dim_all)
    );

    colmix_prio #(.PAL_AW(PAL_AW)) u_prio (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .lhbl       (lhbl),
        .lvbl       (lvbl),
        .fix_pxl    (fix_pxl),
        .lyra_pxl   (lyra_pxl),
        .lyrb_pxl   (lyrb_pxl),
        .obj_pxl    (obj_pxl),
        .obj_pri    (obj_pri),
        .shadow     (shadow),
        .obj_over_a (obj_over_a),
        .pal_addr   (pal_addr),
        .shade      (shade),
        .blank_n    (blank_n)
    );

    colmix_pal_ram #(.PAL_AW(PAL_AW)) u_pal (
        .clk           (clk),
        .pxl_cen       (pxl_cen),
        .pal_cpu_addr  (pal_cpu_addr),
        .pal_cpu_we    (pal_cpu_we),
        .pal_cpu_wdata (pal_cpu_wdata),
        .pal_cpu_rdata (pal_cpu_rdata),
        .pal_addr      (pal_addr),
        .shade_in      (shade),
        .blank_n_in    (blank_n),
        .pal_color     (pal_color),
        .shade_out     (shade_d),
        .blank_n_out   (blank_n_d)
    );

    colmix_bright u_bright (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .pal_color (pal_color),
        .shade     (shade_d),
        .blank_n   (blank_n_d),
        .dim       (dim),
        .dim_pol   (dim_pol),
        .dim_all   (dim_all),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

endmodule

// ==== verif/colmix_tb.sv ====
// testbench for colmix_top, replays the trace file over APB and the pixel inputs and checks results
`timescale 1ns/10ps

module colmix_tb;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [12:0] paddr;
    logic [15:0] pwdata;
    logic [15:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        pxl_cen;
    logic        lhbl;
    logic        lvbl;
    logic [7:0]  fix_pxl;
    logic [8:0]  lyra_pxl;
    logic [8:0]  lyrb_pxl;
    logic [8:0]  obj_pxl;
    logic [1:0]  obj_pri;
    logic        shadow;
    logic [7:0]  red;
    logic [7:0]  green;
    logic [7:0]  blue;

    logic [31:0] seed = 32'h8ee9ef9c;
    logic [31:0] pulse_cnt = 0;
    int          cycles = 0;
    int          limit = 0;
    // target pulse count in the top bits, then expected r, g, b
    logic [55:0] exp_q[$];

    colmix_top #(.PAL_AW(11)) dut (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .pxl_cen(pxl_cen), .lhbl(lhbl), .lvbl(lvbl), .fix_pxl(fix_pxl),
        .lyra_pxl(lyra_pxl), .lyrb_pxl(lyrb_pxl), .obj_pxl(obj_pxl), .obj_pri(obj_pri),
        .shadow(shadow), .red(red), .green(green), .blue(blue)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_val(input string sig, input logic [15:0] exp_v, input logic [15:0] act_v);
        assert (exp_v === act_v) else stop_run($sformatf(
            "MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, sig, exp_v, act_v));
    endtask

    // pixel enable on every second cycle, plus the run limit
    always @(posedge clk) begin
        pxl_cen <= ~pxl_cen;
        if (pxl_cen) pulse_cnt <= pulse_cnt + 32'd1;
        cycles <= cycles + 1;
        if (limit > 0) begin
            assert (cycles < limit) else stop_run("timeout, the trace did not finish in time");
        end
    end

    // outputs settle after the pulse edge and hold until the next pulse
    always @(negedge clk) begin
        if (exp_q.size() > 0 && exp_q[0][55:24] == pulse_cnt) begin
            check_val("red", {8'h00, exp_q[0][23:16]}, {8'h00, red});
            check_val("green", {8'h00, exp_q[0][15:8]}, {8'h00, green});
            check_val("blue", {8'h00, exp_q[0][7:0]}, {8'h00, blue});
            void'(exp_q.pop_front());
        end
    end

    task automatic wait_drain();
        while (exp_q.size() != 0) @(posedge clk);
    endtask

    task automatic apb_xfer(input logic wr, input logic [12:0] addr, input logic [15:0] wdata,
                            output logic [15:0] rdata, output logic err, output int waits);
        int idle;
        seed = lcg_next(seed);
        idle = int'(seed[31:30]);
        repeat (idle) @(posedge clk);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        waits = 0;
        @(negedge clk);
        while (!pready) begin
            waits++;
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // drive on the edge before a pulse, so the pulse samples the new pixel
    task automatic drive_pixel(input logic [31:0] f[11]);
        @(posedge clk);
        while (pxl_cen) @(posedge clk);
        fix_pxl  <= f[0][7:0];
        lyra_pxl <= f[1][8:0];
        lyrb_pxl <= f[2][8:0];
        obj_pxl  <= f[3][8:0];
        obj_pri  <= f[4][1:0];
        shadow   <= f[5][0];
        lhbl     <= f[6][0];
        lvbl     <= f[7][0];
        exp_q.push_back({pulse_cnt + 32'd3, f[8][7:0], f[9][7:0], f[10][7:0]});
    endtask

    initial begin
        int               fd;
        int               rc;
        int               n_lines;
        int               waits;
        logic [8*256-1:0] line;
        logic [63:0]      tok;
        logic [31:0]      f[11];
        logic [15:0]      rd;
        logic             err;
        clk = 1'b0;
        rst = 1'b1;
        {psel, penable, pwrite, paddr, pwdata} = '0;
        {pxl_cen, lhbl, lvbl, fix_pxl, lyra_pxl, lyrb_pxl, obj_pxl, obj_pri, shadow} = '0;
        fd = $fopen("verif/colmix_trace.txt", "r");
        if (fd == 0) stop_run("cannot open the trace file verif/colmix_trace.txt");
        n_lines = 0;
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc > 0) n_lines++;
        end
        $fclose(fd);
        limit = 40 * n_lines + 200;
        fd = $fopen("verif/colmix_trace.txt", "r");
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                rc = $fgets(line, fd);
            end else if (tok == "W") begin
                rc = $fscanf(fd, "%h %h", f[0], f[1]);
                if (rc != 2) stop_run("malformed write line in the trace");
                wait_drain();
                apb_xfer(1'b1, f[0][12:0], f[1][15:0], rd, err, waits);
            end else if (tok == "R") begin
                rc = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
                if (rc != 3) stop_run("malformed read line in the trace");
                wait_drain();
                apb_xfer(1'b0, f[0][12:0], 16'h0000, rd, err, waits);
                check_val("prdata", f[1][15:0], rd);
                check_val("pslverr", {15'b0, f[2][0]}, {15'b0, err});
                // a good palette read has exactly one wait state
                check_val("wait_states", (!f[2][0] && f[0] < 32'h1000) ? 16'd1 : 16'd0,
                          16'(waits));
            end else if (tok == "P") begin
                rc = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                             f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
                if (rc != 11) stop_run("malformed pixel line in the trace");
                drive_pixel(f);
            end else begin
                stop_run("unknown operation in the trace");
            end
        end
        $fclose(fd);
        wait_drain();
        $display("No errors");
        $finish;
    end

endmodule

// ==== verif/colmix_trace.txt ====
# W addr data | R addr exp_data exp_err   (hex, byte addresses)
# P fix a b obj pri shadow lhbl lvbl exp_r exp_g exp_b   (hex)
W 0000 001F
W 000A 03E0
W 0424 7C00
W 0846 168A
W 0C68 7E01
R 0846 168A 0
R 0C68 7E01 0
R 0003 0000 1
W 1004 000F
R 1004 0000 1
R 1000 0000 0
P 05 023 034 012 0 0 1 1 00 FF 00
P 00 023 034 012 0 0 1 1 52 A5 29
P 00 020 034 012 0 0 1 1 00 00 FF
P 00 020 034 010 0 0 1 1 08 84 FF
P 00 020 030 010 0 0 1 1 FF 00 00
P 05 023 034 012 0 0 0 1 00 00 00
P 05 023 034 012 0 0 1 0 00 00 00
W 1000 0005
P 00 023 034 012 0 0 1 1 00 00 FF
P 00 023 034 012 1 0 1 1 52 A5 29
P 00 023 034 012 2 0 1 1 00 00 FF
P 00 023 034 012 3 0 1 1 52 A5 29
R 1000 0005 0
W 1002 0004
P 00 023 034 01F 0 1 1 1 29 52 14
W 1002 000C
P 00 023 034 012 1 0 1 1 29 52 14
P 00 023 034 01F 1 1 1 1 52 A5 29
W 1002 0016
P 05 000 000 000 0 0 1 1 00 3F 00
R 1002 0016 0

// ==== sim.f ====
design/colmix_video_pkg.sv
design/colmix_regs_pkg.sv
design/colmix_apb.sv
design/colmix_prio.sv
design/colmix_pal_ram.sv
design/colmix_bright.sv
design/colmix_top.sv
verif/colmix_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module colmix_tb -o colmix_sim &&
./obj_dir/colmix_sim || { echo "simulation failed"; exit 1; }
